/* files.f */
+incdir+common
common/l1d_pkg.sv
common/l1_array_if.sv
mempipe/mem_arbiter.sv
mempipe/mempipe.sv
l1_arrays/l1_arrays.sv
verilog/l1d_top.sv
tests/l1d_tb.sv

/* Makefile */
# Verilator flow for the L1 data cache pipeline

LOG = sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module l1d_top -f files.f

sim:
	verilator --binary --timing --assert --top-module l1d_tb -f files.f -o sim_l1d
	./obj_dir/sim_l1d | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tests/l1d_tb.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l1d_config.svh"

module l1d_tb;
    import l1d_pkg::*;

    localparam int CLK_PERIOD    = 40;
    localparam int RESET_CYCLES  = 16;
    localparam int DIRECTED_REQS = 39;
    localparam int RANDOM_REQS   = 200;
    localparam int TOTAL_REQS    = DIRECTED_REQS + RANDOM_REQS;
    localparam int NW            = `L1D_NUM_WAYS;
    localparam int NS            = `L1D_NUM_SETS;
    localparam int LAT           = `L1D_NUM_STAGES - 1;

    logic     clk;
    logic     reset;
    logic     ld_req;
    t_paddr   ld_addr;
    t_req_id  ld_id;
    logic     ld_gnt;
    logic     st_req;
    t_paddr   st_addr;
    t_qword   st_data;
    t_req_id  st_id;
    logic     st_gnt;
    logic     fill_req;
    t_paddr   fill_addr;
    t_req_id  fill_id;
    t_cl      fill_line;
    t_mesi    fill_state;
    t_way_idx fill_way;
    logic     fill_gnt;
    logic     res_valid;
    t_mem_op  res_op;
    t_req_id  res_id;
    logic     res_hit;
    t_qword   res_data;

    // Shadow copy of the cache contents
    t_l1_tag                       model_tag   [NS][NW];
    t_mesi                         model_state [NS][NW];
    logic [8*`L1D_LINE_BYTES-1:0]  model_line  [NS][NW];

    // Expected results by age with index 0 at the grant cycle
    logic    exp_valid [0:LAT];
    t_mem_op exp_op    [0:LAT];
    t_req_id exp_id    [0:LAT];
    logic    exp_hit   [0:LAT];
    t_qword  exp_data  [0:LAT];

    int          grants_made;
    int          results_seen;
    int          quiet_now;
    int          quiet_left;
    logic [31:0] lcg_state;
    string       test_name;
    logic        any_gnt;

    assign any_gnt = ld_gnt | st_gnt | fill_gnt;

    l1d_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic stop_with_failure(input string why);
        $display("ERROR: %s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic report_mismatch(input string what, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("MISMATCH %s %s: expected %h actual %h", test_name, what, expected, actual);
        stop_with_failure($sformatf("%s differs from the cache model", what));
    endtask

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic t_paddr make_addr(input int tag, input int set, input int offset);
        return {t_l1_tag'(tag), t_l1_set_addr'(set), t_cl_offset'(offset)};
    endfunction

    // Every byte depends on the full line address
    function automatic t_cl line_from_addr(input t_paddr addr);
        logic [8*`L1D_LINE_BYTES-1:0] line;
        for (int b = 0; b < `L1D_LINE_BYTES; b++) begin
            line[8*b +: 8] = addr[11:4] ^ addr[19:12] ^ addr[27:20] ^ {4'h0, addr[31:28]}
                           ^ 8'(b * 17);
        end
        return line;
    endfunction

    // Way that holds the tag in a usable state or -1 if none
    function automatic int find_way(input t_paddr addr, input logic need_owner);
        int set;
        int way;
        set = int'(addr[L1_SET_HI:L1_SET_LO]);
        way = -1;
        for (int w = 0; w < NW; w++) begin
            if (model_tag[set][w] == addr[L1_TAG_HI:L1_TAG_LO]
                && (need_owner ? (model_state[set][w] == MESI_M || model_state[set][w] == MESI_E)
                               : (model_state[set][w] != MESI_I))) begin
                way = w;
            end
        end
        return way;
    endfunction

    function automatic t_qword rotate_line(input logic [8*`L1D_LINE_BYTES-1:0] line,
                                           input int offset);
        t_qword q;
        for (int b = 0; b < 8; b++) begin
            q[8*b +: 8] = line[8*((offset + b) % `L1D_LINE_BYTES) +: 8];
        end
        return q;
    endfunction

    task automatic record_expect(input t_mem_op op, input t_req_id id, input logic hit,
                                 input t_qword data);
        exp_valid[0] = 1'b1;
        exp_op[0]    = op;
        exp_id[0]    = id;
        exp_hit[0]   = hit;
        exp_data[0]  = data;
        grants_made++;
    endtask

    // Grants and results are stable at the falling edge
    always @(negedge clk) begin
        int set;
        int way;
        if (reset) begin
            for (int s = 0; s < NS; s++) begin
                for (int w = 0; w < NW; w++) begin
                    model_tag[s][w]   = '0;
                    model_state[s][w] = MESI_I;
                    model_line[s][w]  = '0;
                end
            end
            for (int a = 0; a <= LAT; a++) begin
                exp_valid[a] = 1'b0;
            end
            quiet_now  = 0;
            quiet_left = 0;
        end else begin
            for (int a = LAT; a > 0; a--) begin
                exp_valid[a] = exp_valid[a-1];
                exp_op[a]    = exp_op[a-1];
                exp_id[a]    = exp_id[a-1];
                exp_hit[a]   = exp_hit[a-1];
                exp_data[a]  = exp_data[a-1];
            end
            exp_valid[0] = 1'b0;
            if (res_valid) begin
                results_seen++;
            end
            quiet_now  = quiet_left;
            quiet_left = (st_gnt || fill_gnt) ? 4 : (quiet_left > 0 ? quiet_left - 1 : 0);
            if (fill_gnt) begin
                set = int'(fill_addr[L1_SET_HI:L1_SET_LO]);
                model_tag[set][fill_way]   = fill_addr[L1_TAG_HI:L1_TAG_LO];
                model_state[set][fill_way] = fill_state;
                model_line[set][fill_way]  = fill_line;
                record_expect(MEM_FILL, fill_id, 1'b0, '0);
            end else if (st_gnt) begin
                set = int'(st_addr[L1_SET_HI:L1_SET_LO]);
                way = find_way(st_addr, 1'b1);
                if (way >= 0) begin
                    model_line[set][way][64*st_addr[L1_QW_LO] +: 64] = st_data;
                    model_state[set][way] = MESI_M;
                end
                record_expect(MEM_STORE, st_id, way >= 0, '0);
            end else if (ld_gnt) begin
                set = int'(ld_addr[L1_SET_HI:L1_SET_LO]);
                way = find_way(ld_addr, 1'b0);
                if (way >= 0) begin
                    record_expect(MEM_LOAD, ld_id, 1'b1,
                                  rotate_line(model_line[set][way], int'(ld_addr[3:0])));
                end else begin
                    record_expect(MEM_LOAD, ld_id, 1'b0, '0);
                end
            end
        end
    end

    a_res_known: assert property (@(posedge clk) disable iff (reset)
        res_valid |-> exp_valid[LAT])
        else stop_with_failure("result appeared with no request due in this cycle");

    a_res_on_time: assert property (@(posedge clk) disable iff (reset)
        exp_valid[LAT] |-> res_valid)
        else report_mismatch("res_valid", 64'd1, 64'($sampled(res_valid)));

    a_res_id: assert property (@(posedge clk) disable iff (reset)
        exp_valid[LAT] |-> res_id == exp_id[LAT])
        else report_mismatch("res_id", 64'(exp_id[LAT]), 64'($sampled(res_id)));

    a_res_op: assert property (@(posedge clk) disable iff (reset)
        exp_valid[LAT] |-> res_op == exp_op[LAT])
        else report_mismatch("res_op", 64'(exp_op[LAT]), 64'($sampled(res_op)));

    a_res_hit: assert property (@(posedge clk) disable iff (reset)
        exp_valid[LAT] && exp_op[LAT] != MEM_FILL |-> res_hit == exp_hit[LAT])
        else report_mismatch("res_hit", 64'(exp_hit[LAT]), 64'($sampled(res_hit)));

    a_res_data: assert property (@(posedge clk) disable iff (reset)
        exp_valid[LAT] && exp_op[LAT] == MEM_LOAD && exp_hit[LAT] |-> res_data == exp_data[LAT])
        else report_mismatch("res_data", exp_data[LAT], $sampled(res_data));

    a_gnt_requested: assert property (@(posedge clk) disable iff (reset)
        ({fill_gnt, st_gnt, ld_gnt} & ~{fill_req, st_req, ld_req}) == 3'b000)
        else stop_with_failure("grant given to a port that made no request");

    a_fill_first: assert property (@(posedge clk) disable iff (reset)
        fill_req && quiet_now == 0 |-> fill_gnt && !st_gnt && !ld_gnt)
        else stop_with_failure("pending fill was not granted first");

    a_store_second: assert property (@(posedge clk) disable iff (reset)
        st_req && !fill_req && quiet_now == 0 |-> st_gnt && !ld_gnt)
        else stop_with_failure("pending store lost to a load");

    a_load_last: assert property (@(posedge clk) disable iff (reset)
        ld_req && !fill_req && !st_req && quiet_now == 0 |-> ld_gnt)
        else stop_with_failure("lone load request was not granted");

    a_busy_no_gnt: assert property (@(posedge clk) disable iff (reset)
        dut0.write_busy |-> !any_gnt)
        else stop_with_failure("grant given while a write was in flight");

    a_write_gap: assert property (@(posedge clk) disable iff (reset)
        quiet_now != 0 |-> !any_gnt)
        else stop_with_failure("grant within four cycles of a store or fill grant");

    // Hold every raised request until its grant and then drop it
    task automatic wait_grants();
        logic took_ld;
        logic took_st;
        logic took_fill;
        while (ld_req || st_req || fill_req) begin
            @(negedge clk);
            took_ld   = ld_gnt;
            took_st   = st_gnt;
            took_fill = fill_gnt;
            @(posedge clk);
            #2;
            if (took_ld) ld_req = 1'b0;
            if (took_st) st_req = 1'b0;
            if (took_fill) fill_req = 1'b0;
        end
    endtask

    task automatic post_load(input t_paddr addr);
        ld_addr = addr;
        ld_id   = t_req_id'(lcg_next());
        ld_req  = 1'b1;
    endtask

    task automatic post_store(input t_paddr addr, input t_qword data);
        st_addr = addr;
        st_data = data;
        st_id   = t_req_id'(lcg_next());
        st_req  = 1'b1;
    endtask

    task automatic post_fill(input t_paddr addr, input t_cl line, input t_mesi state,
                             input int way);
        fill_addr  = addr;
        fill_line  = line;
        fill_state = state;
        fill_way   = t_way_idx'(way);
        fill_id    = t_req_id'(lcg_next());
        fill_req   = 1'b1;
    endtask

    initial begin
        #((RESET_CYCLES + TOTAL_REQS * 10) * CLK_PERIOD);
        stop_with_failure("watchdog expired before all requests completed");
    end

    initial begin
        t_paddr      addr;
        logic [31:0] r;
        int          way;
        reset      = 1'b1;
        ld_req     = 1'b0;
        ld_addr    = '0;
        ld_id      = '0;
        st_req     = 1'b0;
        st_addr    = '0;
        st_data    = '0;
        st_id      = '0;
        fill_req   = 1'b0;
        fill_addr  = '0;
        fill_id    = '0;
        fill_line  = '0;
        fill_state = MESI_I;
        fill_way   = '0;
        grants_made  = 0;
        results_seen = 0;
        lcg_state    = 32'd74;
        test_name    = "reset";
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
        repeat (4) @(posedge clk);
        #2;

        // Nothing is valid after reset
        for (int i = 0; i < 4; i++) begin
            post_load(make_addr(i, (i * 5) % NS, i * 4 + 3));
            wait_grants();
        end

        test_name = "load_offsets";
        addr = make_addr('h123456, 5, 0);
        post_fill(addr, line_from_addr(addr), MESI_E, 2);
        wait_grants();
        for (int off = 0; off < `L1D_LINE_BYTES; off++) begin
            post_load(addr + off);
            wait_grants();
        end

        test_name = "store_merge";
        addr = make_addr('h3a, 3, 0);
        post_fill(addr, line_from_addr(addr), MESI_E, 0);
        wait_grants();
        post_store(addr + 8, 64'h0123_4567_89ab_cdef);
        wait_grants();
        post_load(addr + 4);
        wait_grants();
        addr = make_addr('h3b, 3, 0);
        post_fill(addr, line_from_addr(addr), MESI_M, 1);
        wait_grants();
        post_store(addr + 3, 64'hfeed_face_cafe_f00d);
        wait_grants();
        post_load(addr);
        wait_grants();
        addr = make_addr('h3c, 3, 0);
        post_fill(addr, line_from_addr(addr), MESI_S, 2);
        wait_grants();
        post_store(addr + 8, 64'h1111_2222_3333_4444);
        wait_grants();
        post_load(addr + 8);
        wait_grants();
        // Matching tag held in state I
        addr = make_addr('h3d, 3, 0);
        post_fill(addr, line_from_addr(addr), MESI_I, 3);
        wait_grants();
        post_store(addr, 64'h5555_6666_7777_8888);
        wait_grants();
        post_load(addr);
        wait_grants();

        test_name = "priority";
        for (int i = 0; i < 2; i++) begin
            addr = make_addr('h777 + i, 7, 0);
            post_fill(addr, line_from_addr(addr), i == 0 ? MESI_E : MESI_S, 3 - i);
            post_store(addr + 8, {lcg_next(), lcg_next()});
            post_load(addr + 6);
            wait_grants();
        end

        test_name = "random_mix";
        for (int n = 0; n < RANDOM_REQS; n++) begin
            r    = lcg_next();
            addr = make_addr('h400 + int'(r[17:16]) % 3, 8 + int'(r[5:4]), int'(r[3:0]));
            if (r[31:30] == 2'd0) begin
                way = find_way(addr, 1'b0);
                if (way < 0) way = int'(r[21:20]);
                post_fill(addr, {lcg_next(), lcg_next(), lcg_next(), lcg_next()},
                          t_mesi'(1 + int'(r[23:22]) % 3), way);
            end else if (r[31:30] == 2'd1) begin
                post_store(addr, {lcg_next(), lcg_next()});
            end else begin
                post_load(addr);
            end
            wait_grants();
        end

        test_name = "drain";
        while (results_seen != grants_made) @(negedge clk);
        // Last result is checked on the next rising edge
        @(posedge clk);
        #2;
        if (grants_made == TOTAL_REQS) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            stop_with_failure($sformatf("expected %0d grants, saw %0d",
                                        TOTAL_REQS, grants_made));
        end
    end

endmodule

`default_nettype wire

/* verilog/l1d_top.sv */
`timescale 1ns/10ps
`default_nettype none

module l1d_top (
    input  logic              clk,
    input  logic              reset,

    input  logic              ld_req,
    input  l1d_pkg::t_paddr   ld_addr,
    input  l1d_pkg::t_req_id  ld_id,
    output logic              ld_gnt,

    input  logic              st_req,
    input  l1d_pkg::t_paddr   st_addr,
    input  l1d_pkg::t_qword   st_data,
    input  l1d_pkg::t_req_id  st_id,
    output logic              st_gnt,

    input  logic              fill_req,
    input  l1d_pkg::t_paddr   fill_addr,
    input  l1d_pkg::t_req_id  fill_id,
    input  l1d_pkg::t_cl      fill_line,
    input  l1d_pkg::t_mesi    fill_state,
    input  l1d_pkg::t_way_idx fill_way,
    output logic              fill_gnt,

    output logic              res_valid,
    output l1d_pkg::t_mem_op  res_op,
    output l1d_pkg::t_req_id  res_id,
    output logic              res_hit,
    output l1d_pkg::t_qword   res_data
);
    import l1d_pkg::*;

    t_mempipe_req ld_pkt;
    t_mempipe_req st_pkt;
    t_mempipe_req fill_pkt;
    t_mempipe_req req_mm0;
    logic         valid_mm0;
    logic         write_busy;

    l1_array_if arr ();

    // Pack the port fields, unused fields stay zero
    always_comb begin
        ld_pkt              = '0;
        ld_pkt.op           = MEM_LOAD;
        ld_pkt.addr         = ld_addr;
        ld_pkt.id           = ld_id;

        st_pkt              = '0;
        st_pkt.op           = MEM_STORE;
        st_pkt.addr         = st_addr;
        st_pkt.id           = st_id;
        st_pkt.st_data      = st_data;

        fill_pkt            = '0;
        fill_pkt.op         = MEM_FILL;
        fill_pkt.addr       = fill_addr;
        fill_pkt.id         = fill_id;
        fill_pkt.fill_line  = fill_line;
        fill_pkt.fill_state = fill_state;
        fill_pkt.fill_way   = fill_way;
    end

    mem_arbiter arb0 (.*);

    mempipe pipe0 (.*);

    l1_arrays arrays0 (.*);

endmodule

`default_nettype wire

/* l1_arrays/l1_arrays.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l1d_config.svh"

module l1_arrays (
    input  logic      clk,
    input  logic      reset,
    l1_array_if.array arr
);
    import l1d_pkg::*;

    localparam int NW = `L1D_NUM_WAYS;
    localparam int NS = `L1D_NUM_SETS;

    t_l1_tag tag_mem   [NS][NW];
    t_mesi   state_mem [NS][NW];
    t_cl     data_mem  [NS][NW];

    // Tag and line storage
    always_ff @(posedge clk) begin
        if (arr.wr_en) begin
            for (int w = 0; w < NW; w++) begin
                if (arr.wr_way[w]) begin
                    tag_mem[arr.wr_set][w]  <= arr.wr_tag;
                    data_mem[arr.wr_set][w] <= arr.wr_line;
                end
            end
        end
        // Read sees the old contents when it meets a write to the same set
        if (arr.rd_en) begin
            for (int w = 0; w < NW; w++) begin
                arr.tag_ways[w]  <= tag_mem[arr.rd_set][w];
                arr.data_ways[w] <= data_mem[arr.rd_set][w];
            end
        end
    end

    // State, every line invalid out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = 0; s < NS; s++) begin
                for (int w = 0; w < NW; w++) begin
                    state_mem[s][w] <= MESI_I;
                end
            end
            for (int w = 0; w < NW; w++) begin
                arr.state_ways[w] <= MESI_I;
            end
        end else begin
            if (arr.wr_en) begin
                for (int w = 0; w < NW; w++) begin
                    if (arr.wr_way[w]) begin
                        state_mem[arr.wr_set][w] <= arr.wr_state;
                    end
                end
            end
            if (arr.rd_en) begin
                for (int w = 0; w < NW; w++) begin
                    arr.state_ways[w] <= state_mem[arr.rd_set][w];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* mempipe/mempipe.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l1d_config.svh"

module mempipe (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  valid_mm0,
    input  l1d_pkg::t_mempipe_req req_mm0,
    output logic                  write_busy,
    l1_array_if.pipe              arr,
    output logic                  res_valid,
    output l1d_pkg::t_mem_op      res_op,
    output l1d_pkg::t_req_id      res_id,
    output logic                  res_hit,
    output l1d_pkg::t_qword       res_data
);
    import l1d_pkg::*;

    localparam int NW  = `L1D_NUM_WAYS;
    localparam int MM1 = 1;
    localparam int MM2 = 2;
    localparam int MM4 = 4;
    localparam int MM5 = `L1D_NUM_STAGES - 1;

    logic          valid_mmx [MM1:MM5];
    t_mempipe_req  req_mmx   [MM1:MM5];

    logic [NW-1:0] hit_vec_mm2;
    logic [NW-1:0] hit_vec_mm3;
    logic [NW-1:0] hit_vec_mm4;
    logic [NW-1:0] hit_vec_mm5;
    t_cl           data_set_mm3 [NW];
    t_cl           line_sel_mm3;
    t_cl           line_mm4;
    t_cl           line_mm5;
    t_qword        rot_mm4;
    t_qword        rot_mm5;
    t_cl           merged_mm5;
    logic [NW-1:0] fill_way_oh_mm5;
    logic          hit_mm5;

    // Stage valids
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int s = MM1; s <= MM5; s++) begin
                valid_mmx[s] <= 1'b0;
            end
        end else begin
            valid_mmx[MM1] <= valid_mm0;
            for (int s = MM2; s <= MM5; s++) begin
                valid_mmx[s] <= valid_mmx[s-1];
            end
        end
    end

    // Request packet rides along with its valid
    always_ff @(posedge clk) begin
        req_mmx[MM1] <= req_mm0;
        for (int s = MM2; s <= MM5; s++) begin
            req_mmx[s] <= req_mmx[s-1];
        end
    end

    // Stores and fills block new grants until they reach mm5
    always_comb begin
        write_busy = 1'b0;
        for (int s = MM1; s < MM5; s++) begin
            write_busy |= valid_mmx[s] && (req_mmx[s].op != MEM_LOAD);
        end
    end

    // mm1: set read, fills need no lookup
    assign arr.rd_en  = valid_mmx[MM1] && (req_mmx[MM1].op != MEM_FILL);
    assign arr.rd_set = req_mmx[MM1].addr[L1_SET_HI:L1_SET_LO];

    // mm2: loads hit on any valid state, stores need ownership
    always_comb begin
        for (int w = 0; w < NW; w++) begin
            hit_vec_mm2[w] = valid_mmx[MM2]
                && (arr.tag_ways[w] == req_mmx[MM2].addr[L1_TAG_HI:L1_TAG_LO])
                && ((req_mmx[MM2].op == MEM_LOAD && arr.state_ways[w] != MESI_I)
                 || (req_mmx[MM2].op == MEM_STORE
                     && arr.state_ways[w] inside {MESI_M, MESI_E}));
        end
    end

    always_ff @(posedge clk) begin
        hit_vec_mm3  <= hit_vec_mm2;
        data_set_mm3 <= arr.data_ways;
    end

    // mm3: and-or way select
    always_comb begin
        line_sel_mm3 = '0;
        for (int w = 0; w < NW; w++) begin
            line_sel_mm3 = line_sel_mm3 | (data_set_mm3[w] & {$bits(t_cl){hit_vec_mm3[w]}});
        end
    end

    always_ff @(posedge clk) begin
        hit_vec_mm4 <= hit_vec_mm3;
        line_mm4    <= line_sel_mm3;
    end

    // mm4: addressed byte to byte 0, offset wraps inside the line
    always_comb begin
        t_cl_offset o;
        o = req_mmx[MM4].addr[L1_OFFSET_HI:L1_OFFSET_LO];
        for (int b = 0; b < 8; b++) begin
            rot_mm4[8*b +: 8] = line_mm4.bytes[o];
            o += 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        hit_vec_mm5 <= hit_vec_mm4;
        line_mm5    <= line_mm4;
        rot_mm5     <= rot_mm4;
    end

    // mm5: result and array write
    assign hit_mm5 = |hit_vec_mm5;

    always_comb begin
        merged_mm5 = line_mm5;
        merged_mm5.qwords[req_mmx[MM5].addr[L1_OFFSET_HI:L1_QW_LO]] = req_mmx[MM5].st_data;
    end

    always_comb begin
        fill_way_oh_mm5 = '0;
        fill_way_oh_mm5[req_mmx[MM5].fill_way] = 1'b1;
    end

    assign res_valid = valid_mmx[MM5];
    assign res_op    = req_mmx[MM5].op;
    assign res_id    = req_mmx[MM5].id;
    assign res_hit   = hit_mm5;
    assign res_data  = (req_mmx[MM5].op == MEM_LOAD && hit_mm5) ? rot_mm5 : '0;

    assign arr.wr_en    = valid_mmx[MM5]
                        && (req_mmx[MM5].op == MEM_FILL
                         || (req_mmx[MM5].op == MEM_STORE && hit_mm5));
    assign arr.wr_set   = req_mmx[MM5].addr[L1_SET_HI:L1_SET_LO];
    assign arr.wr_tag   = req_mmx[MM5].addr[L1_TAG_HI:L1_TAG_LO];
    assign arr.wr_way   = (req_mmx[MM5].op == MEM_FILL) ? fill_way_oh_mm5 : hit_vec_mm5;
    assign arr.wr_state = (req_mmx[MM5].op == MEM_FILL) ? req_mmx[MM5].fill_state : MESI_M;
    assign arr.wr_line  = (req_mmx[MM5].op == MEM_FILL) ? req_mmx[MM5].fill_line : merged_mm5;

    // A tag lives in at most one way of a set
    a_hit_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(hit_vec_mm2))
        else $error("tag present in more than one way");

    a_wr_way_onehot: assert property (@(posedge clk) disable iff (reset)
        arr.wr_en |-> $onehot(arr.wr_way))
        else $error("array write without a single target way");

endmodule

`default_nettype wire

/* mempipe/mem_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  ld_req,
    input  logic                  st_req,
    input  logic                  fill_req,
    input  l1d_pkg::t_mempipe_req ld_pkt,
    input  l1d_pkg::t_mempipe_req st_pkt,
    input  l1d_pkg::t_mempipe_req fill_pkt,
    input  logic                  write_busy,
    output logic                  ld_gnt,
    output logic                  st_gnt,
    output logic                  fill_gnt,
    output logic                  valid_mm0,
    output l1d_pkg::t_mempipe_req req_mm0
);
    import l1d_pkg::*;

    // Fixed priority: fill, then store, then load
    always_comb begin
        ld_gnt     = 1'b0;
        st_gnt     = 1'b0;
        fill_gnt   = 1'b0;
        req_mm0    = ld_pkt;
        req_mm0.op = MEM_LOAD;
        if (!write_busy) begin
            if (fill_req) begin
                fill_gnt   = 1'b1;
                req_mm0    = fill_pkt;
                req_mm0.op = MEM_FILL;
            end else if (st_req) begin
                st_gnt     = 1'b1;
                req_mm0    = st_pkt;
                req_mm0.op = MEM_STORE;
            end else if (ld_req) begin
                ld_gnt     = 1'b1;
            end
        end
    end

    assign valid_mm0 = fill_gnt | st_gnt | ld_gnt;

    a_gnt_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0({fill_gnt, st_gnt, ld_gnt}))
        else $error("more than one port granted");

    // Pipe stays quiet while a write works its way to mm5
    a_write_quiet: assert property (@(posedge clk) disable iff (reset)
        (fill_gnt || st_gnt) |=> !valid_mm0 [*4])
        else $error("grant issued behind a store or fill");

endmodule

`default_nettype wire

/* common/l1_array_if.sv */
`timescale 1ns/10ps
`default_nettype none

`include "l1d_config.svh"

interface l1_array_if;
    import l1d_pkg::*;

    // Set read, issued in mm1
    logic         rd_en;
    t_l1_set_addr rd_set;

    // Every way of the set, returned in mm2
    t_l1_tag      tag_ways   [`L1D_NUM_WAYS];
    t_mesi        state_ways [`L1D_NUM_WAYS];
    t_cl          data_ways  [`L1D_NUM_WAYS];

    // Write from mm5, wr_way is one-hot
    logic                     wr_en;
    t_l1_set_addr             wr_set;
    logic [`L1D_NUM_WAYS-1:0] wr_way;
    t_l1_tag                  wr_tag;
    t_mesi                    wr_state;
    t_cl                      wr_line;

    modport pipe (
        output rd_en, rd_set,
        input  tag_ways, state_ways, data_ways,
        output wr_en, wr_set, wr_way, wr_tag, wr_state, wr_line
    );

    modport array (
        input  rd_en, rd_set,
        output tag_ways, state_ways, data_ways,
        input  wr_en, wr_set, wr_way, wr_tag, wr_state, wr_line
    );

endinterface

`default_nettype wire

/* common/l1d_pkg.sv */
`default_nettype none

`include "l1d_config.svh"

package l1d_pkg;

    // Address split: | tag | set | offset |
    localparam int L1_OFFSET_LO = 0;
    localparam int L1_OFFSET_HI = $clog2(`L1D_LINE_BYTES) - 1;
    localparam int L1_SET_LO    = L1_OFFSET_HI + 1;
    localparam int L1_SET_HI    = L1_SET_LO + $clog2(`L1D_NUM_SETS) - 1;
    localparam int L1_TAG_LO    = L1_SET_HI + 1;
    localparam int L1_TAG_HI    = `L1D_PADDR_W - 1;

    // Lowest address bit that picks a qword within the line
    localparam int L1_QW_LO     = 3;
    localparam int L1_QWORDS    = `L1D_LINE_BYTES / 8;
    localparam int L1_WAY_W     = $clog2(`L1D_NUM_WAYS);

    typedef logic [`L1D_PADDR_W-1:0]         t_paddr;
    typedef logic [L1_TAG_HI-L1_TAG_LO:0]    t_l1_tag;
    typedef logic [L1_SET_HI-L1_SET_LO:0]    t_l1_set_addr;
    typedef logic [L1_OFFSET_HI:L1_OFFSET_LO] t_cl_offset;
    typedef logic [L1_WAY_W-1:0]             t_way_idx;
    typedef logic [3:0]                      t_req_id;

    // Load result and store payload
    typedef logic [63:0]                     t_qword;

    typedef enum logic [1:0] {
        MESI_I,
        MESI_S,
        MESI_E,
        MESI_M
    } t_mesi;

    typedef enum logic [1:0] {
        MEM_LOAD,
        MEM_STORE,
        MEM_FILL
    } t_mem_op;

    // Byte view for the load rotate, qword view for the store merge
    typedef union packed {
        logic [`L1D_LINE_BYTES-1:0][7:0] bytes;
        logic [L1_QWORDS-1:0][63:0]      qwords;
    } t_cl;

    typedef struct packed {
        t_mem_op  op;
        t_paddr   addr;
        t_req_id  id;
        t_qword   st_data;
        t_cl      fill_line;
        t_mesi    fill_state;
        t_way_idx fill_way;
    } t_mempipe_req;

endpackage

`default_nettype wire

/* common/l1d_config.svh */
`ifndef L1D_CONFIG_SVH
`define L1D_CONFIG_SVH

// Cache geometry
`define L1D_NUM_WAYS    4
`define L1D_NUM_SETS    16
`define L1D_LINE_BYTES  16

// Physical address width, no translation in front of the cache
`define L1D_PADDR_W     32

// mm0 through mm5
`define L1D_NUM_STAGES  6

`endif
